//--- compile.f
+incdir+include
logic/rv_core_pkg.sv
logic/rv_pipe_if.sv
logic/rv_if_stage.sv
logic/rv_ex_stage.sv
logic/rv_register_file.sv
logic/rv_load_store_unit.sv
logic/rv_core.sv
sim/tb_clock_gen.sv
sim/tb_instr_mem.sv
sim/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

//--- sim/tb_rv_core.sv
/*
 * Directed tests of the RV32I core
 * Programs go into the fetch model, stores are collected from the data bus
 */
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module tb_rv_core import rv_core_pkg::*; ();

  // Instruction count plus reset per test, times 20 cycles
  localparam int TOTAL_LEN       = 20 + 14 + 16 + 18 + 16;
  localparam int WATCHDOG_CYCLES = TOTAL_LEN * 20;

  logic       clk;
  logic       rst;
  logic       restart;
  logic       fetch_enable;
  word_t      boot_addr;
  logic       instr_req;
  word_t      instr_addr;
  logic       instr_gnt;
  logic       instr_rvalid;
  word_t      instr_rdata;
  logic       data_req;
  logic       data_we;
  logic [3:0] data_be;
  word_t      data_addr;
  word_t      data_wdata;
  logic       data_gnt;
  logic       data_rvalid;
  logic [1:0] instr_delay;
  logic [1:0] data_delay;
  logic [1:0] data_wait;
  logic       random_delays;
  logic       data_held;
  word_t      prev_addr;
  word_t      prev_wdata;
  integer     seed;
  int         errors;
  word_t      op_a;
  word_t      op_b;
  word_t      fetch_q[$];
  word_t      st_addr_q[$];
  word_t      st_data_q[$];
  word_t      exp_addr_q[$];
  word_t      exp_data_q[$];

  tb_clock_gen u_clock_gen (
    .restart_i ( restart ),
    .clk_o     ( clk     ),
    .rst_o     ( rst     )
  );

  tb_instr_mem #(.BASE(32'h100)) u_imem (
    .clk_i       ( clk          ),
    .rst_i       ( rst          ),
    .req_i       ( instr_req    ),
    .addr_i      ( instr_addr   ),
    .gnt_delay_i ( instr_delay  ),
    .gnt_o       ( instr_gnt    ),
    .rvalid_o    ( instr_rvalid ),
    .rdata_o     ( instr_rdata  )
  );

  rv_core UUT (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .fetch_enable_i ( fetch_enable ),
    .boot_addr_i    ( boot_addr    ),
    .instr_req_o    ( instr_req    ),
    .instr_addr_o   ( instr_addr   ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_rdata_i  ( instr_rdata  ),
    .data_req_o     ( data_req     ),
    .data_we_o      ( data_we      ),
    .data_be_o      ( data_be      ),
    .data_addr_o    ( data_addr    ),
    .data_wdata_o   ( data_wdata   ),
    .data_gnt_i     ( data_gnt     ),
    .data_rvalid_i  ( data_rvalid  )
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch at %0t ns: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus responders and monitors
  //////////////////////////////////////////////////

  // Grant delays, redrawn every cycle in random mode
  always @(posedge clk) begin
    instr_delay <= random_delays ? 2'($random(seed)) : 2'd0;
    data_delay  <= random_delays ? 2'($random(seed)) : 2'd0;
  end

  always @(posedge clk) begin
    if (!rst && instr_req && instr_gnt) begin
      fetch_q.push_back(instr_addr);
    end
  end

  // Data bus slave, records each granted store
  always @(posedge clk) begin
    if (rst) begin
      data_gnt    <= 1'b0;
      data_rvalid <= 1'b0;
      data_wait   <= '0;
      data_held   <= 1'b0;
    end else begin
      data_rvalid <= data_req && data_gnt;
      // Pending request must not move before its grant
      if (data_held) begin
        check_bit("data_req_o", 1'b1, data_req);
        check_word("data_addr_o", prev_addr, data_addr);
        check_word("data_wdata_o", prev_wdata, data_wdata);
      end
      if (data_req && data_gnt) begin
        st_addr_q.push_back(data_addr);
        st_data_q.push_back(data_wdata);
        check_bit("data_we_o", 1'b1, data_we);
        check_word("data_be_o", 32'h0000000f, word_t'(data_be));
        data_gnt  <= 1'b0;
        data_wait <= '0;
      end else if (data_req) begin
        if (data_wait >= data_delay) begin
          data_gnt <= 1'b1;
        end else begin
          data_wait <= data_wait + 2'd1;
        end
      end
      data_held  <= data_req && !data_gnt;
      prev_addr  <= data_addr;
      prev_wdata <= data_wdata;
    end
  end

  //////////////////////////////////////////////////
  // Program assembly
  //////////////////////////////////////////////////

  function automatic word_t i_type(logic [11:0] imm, rf_addr_t rs1, logic [2:0] f3,
                                   rf_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t r_type(logic [6:0] f7, rf_addr_t rs2, rf_addr_t rs1,
                                   logic [2:0] f3, rf_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
  endfunction

  function automatic word_t lui_word(rf_addr_t rd, logic [19:0] imm);
    return {imm, rd, `RV_OPC_LUI};
  endfunction

  function automatic word_t sw_word(rf_addr_t rs2, rf_addr_t rs1, logic [11:0] off);
    return {off[11:5], rs2, rs1, `RV_F3_SW, off[4:0], `RV_OPC_STORE};
  endfunction

  task automatic emit_word(input word_t w);
    u_imem.mem[u_imem.prog_len] = w;
    u_imem.prog_len = u_imem.prog_len + 1;
  endtask

  // LUI then ADDI, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input rf_addr_t rd, input word_t v);
    word_t upper;
    upper = (v + 32'h800) >> 12;
    emit_word(lui_word(rd, upper[19:0]));
    emit_word(i_type(v[11:0], rd, `RV_F3_ADD, rd, `RV_OPC_OP_IMM));
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  task automatic restart_core(input word_t boot);
    fetch_enable <= 1'b0;
    boot_addr    <= boot;
    restart      <= 1'b1;
    @(posedge clk);
    restart <= 1'b0;
    u_imem.prog_len = 0;
    fetch_q.delete();
    st_addr_q.delete();
    st_data_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
    @(posedge clk);
    while (rst) begin
      check_bit("instr_req_o", 1'b0, instr_req);
      check_bit("data_req_o", 1'b0, data_req);
      @(posedge clk);
    end
  endtask

  // Start fetching, wait for all expected stores, compare in order
  task automatic run_and_compare();
    fetch_enable <= 1'b1;
    while (st_addr_q.size() < exp_addr_q.size()) begin
      @(posedge clk);
    end
    foreach (exp_addr_q[i]) begin
      check_word("data_addr_o", exp_addr_q[i], st_addr_q[i]);
      check_word("data_wdata_o", exp_data_q[i], st_data_q[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic fetch_start();
    restart_core(32'h180);
    repeat (10) begin
      @(posedge clk);
      check_bit("instr_req_o", 1'b0, instr_req);
    end
    fetch_enable <= 1'b1;
    while (fetch_q.size() < 4) begin
      @(posedge clk);
    end
    for (int i = 0; i < 4; i++) begin
      check_word("instr_addr_o", 32'h180 + 32'(4 * i), fetch_q[i]);
    end
  endtask

  task automatic immediate_forms();
    restart_core(32'h100);
    emit_word(lui_word(5'd1, 20'habcde));
    emit_word(sw_word(5'd1, 5'd0, 12'h008));
    expect_store(32'h8, 32'habcde000);
    emit_word(i_type(12'hffb, 5'd0, `RV_F3_ADD, 5'd2, `RV_OPC_OP_IMM));
    emit_word(i_type(12'h100, 5'd0, `RV_F3_ADD, 5'd3, `RV_OPC_OP_IMM));
    // Negative store offset from the base in x3
    emit_word(sw_word(5'd2, 5'd3, 12'hffc));
    expect_store(32'hfc, 32'hfffffffb);
    run_and_compare();
  endtask

  // Each ALU op reads the result of the one just before it
  task automatic alu_program(input word_t a, input word_t b);
    word_t sum;
    word_t diff;
    word_t mix;
    sum  = a + b;
    diff = sum - a;
    mix  = diff ^ a;
    load_const(5'd5, a);
    load_const(5'd6, b);
    emit_word(r_type(7'b0, 5'd6, 5'd5, `RV_F3_ADD, 5'd7));
    emit_word(r_type(`RV_F7_SUB, 5'd5, 5'd7, `RV_F3_ADD, 5'd8));
    emit_word(r_type(7'b0, 5'd5, 5'd8, `RV_F3_XOR, 5'd9));
    emit_word(sw_word(5'd9, 5'd0, 12'h208));
    emit_word(sw_word(5'd7, 5'd0, 12'h200));
    emit_word(sw_word(5'd8, 5'd0, 12'h204));
    expect_store(32'h208, mix);
    expect_store(32'h200, sum);
    expect_store(32'h204, diff);
  endtask

  task automatic register_ops();
    restart_core(32'h100);
    op_a = $random(seed);
    op_b = $random(seed);
    alu_program(op_a, op_b);
    run_and_compare();
  endtask

  task automatic x0_and_unsupported();
    restart_core(32'h100);
    emit_word(i_type(12'h055, 5'd0, `RV_F3_ADD, 5'd10, `RV_OPC_OP_IMM));
    emit_word(i_type(12'h07b, 5'd0, `RV_F3_ADD, 5'd0, `RV_OPC_OP_IMM));
    emit_word(lui_word(5'd0, 20'hfffff));
    emit_word(sw_word(5'd0, 5'd0, 12'h300));
    expect_store(32'h300, 32'h0);
    // Load, MUL, SLLI and BEQ all target x10 and must do nothing
    emit_word(i_type(12'h000, 5'd0, 3'b010, 5'd10, 7'b0000011));
    emit_word(r_type(7'b0000001, 5'd10, 5'd10, `RV_F3_ADD, 5'd10));
    emit_word(i_type(12'h001, 5'd10, 3'b001, 5'd10, `RV_OPC_OP_IMM));
    emit_word(32'h00a50463);
    emit_word(sw_word(5'd10, 5'd0, 12'h304));
    expect_store(32'h304, 32'h55);
    run_and_compare();
  endtask

  // Same operands as the register test, random grants on both buses
  task automatic backpressure();
    restart_core(32'h100);
    random_delays <= 1'b1;
    alu_program(op_a, op_b);
    run_and_compare();
    random_delays <= 1'b0;
  endtask

  initial begin
    seed          = 32'h3c96;
    errors        = 0;
    restart       = 1'b0;
    fetch_enable  = 1'b0;
    boot_addr     = 32'h100;
    data_gnt      = 1'b0;
    data_rvalid   = 1'b0;
    instr_delay   = 2'd0;
    data_delay    = 2'd0;
    random_delays = 1'b0;
    op_a          = '0;
    op_b          = '0;
    fetch_start();
    immediate_forms();
    register_ops();
    x0_and_unsupported();
    backpressure();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Timeout after %0d cycles, expected stores never completed", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- sim/tb_instr_mem.sv
/*
 * Instruction memory model on the OBI fetch bus
 * Grants after a delay given per cycle, rvalid one cycle after the grant
 */
`timescale 1ns/1ps

module tb_instr_mem import rv_core_pkg::*; #(
  parameter word_t BASE = 32'h100
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       req_i,
  input  word_t      addr_i,
  input  logic [1:0] gnt_delay_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output word_t      rdata_o
);

  // Program words, loaded from the testbench top
  word_t      mem [256];
  int         prog_len;
  logic [1:0] wait_cnt;

  initial begin
    prog_len = 0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    wait_cnt = '0;
  end

  // Outside the program, a fence-like word that the core retires as no-op
  function automatic word_t read_word(word_t a);
    int idx;
    idx = int'((a - BASE) >> 2);
    if (a >= BASE && idx < prog_len) begin
      return mem[idx];
    end
    return {a[31:7] ^ a[24:0], 7'b0001111};
  endfunction

  always @(posedge clk_i) begin
    if (rst_i) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      wait_cnt <= '0;
    end else begin
      rvalid_o <= req_i && gnt_o;
      if (req_i && gnt_o) begin
        rdata_o  <= read_word(addr_i);
        gnt_o    <= 1'b0;
        wait_cnt <= '0;
      end else if (req_i) begin
        if (wait_cnt >= gnt_delay_i) begin
          gnt_o <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 2'd1;
        end
      end
    end
  end

endmodule

//--- sim/tb_clock_gen.sv
/*
 * Testbench clock and reset source, 10 ns period
 * Reset is high for 5 cycles at start and again after each restart pulse
 */
`timescale 1ns/1ps

module tb_clock_gen (
  input  logic restart_i,
  output logic clk_o,
  output logic rst_o
);

  int rst_cnt;

  initial begin
    clk_o   = 1'b0;
    rst_cnt = 0;
  end

  always #5 clk_o = ~clk_o;

  // Count reset cycles, restart starts over
  always @(posedge clk_o) begin
    if (restart_i) begin
      rst_cnt <= 0;
    end else if (rst_cnt < 5) begin
      rst_cnt <= rst_cnt + 1;
    end
  end

  assign rst_o = (rst_cnt < 5);

endmodule

//--- logic/rv_core.sv
/*
 * Top level of the RV32I core
 * Wires fetch, execute, store unit and register file to the two OBI buses
 */
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       fetch_enable_i,
  input  word_t      boot_addr_i,
  // Instruction bus
  output logic       instr_req_o,
  output word_t      instr_addr_o,
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  input  word_t      instr_rdata_i,
  // Data bus
  output logic       data_req_o,
  output logic       data_we_o,
  output logic [3:0] data_be_o,
  output word_t      data_addr_o,
  output word_t      data_wdata_o,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i
);

  // Register file ports
  rf_addr_t rf_raddr_a;
  rf_addr_t rf_raddr_b;
  word_t    rf_rdata_a;
  word_t    rf_rdata_b;
  logic     rf_we;
  rf_addr_t rf_waddr;
  word_t    rf_wdata;

  // Stage links
  rv_pipe_if #(.T(if_id_t))     if_id_bus ();
  rv_pipe_if #(.T(store_req_t)) store_bus ();

  //////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////

  rv_if_stage u_if_stage (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .if_id          ( if_id_bus      )
  );

  //////////////////////////////////////////////////
  // Execute and register file
  //////////////////////////////////////////////////

  rv_ex_stage u_ex_stage (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .if_id        ( if_id_bus  ),
    .store        ( store_bus  ),
    .rf_raddr_a_o ( rf_raddr_a ),
    .rf_raddr_b_o ( rf_raddr_b ),
    .rf_rdata_a_i ( rf_rdata_a ),
    .rf_rdata_b_i ( rf_rdata_b ),
    .rf_we_o      ( rf_we      ),
    .rf_waddr_o   ( rf_waddr   ),
    .rf_wdata_o   ( rf_wdata   )
  );

  rv_register_file u_register_file (
    .clk_i     ( clk_i      ),
    .rst_i     ( rst_i      ),
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b ),
    .we_i      ( rf_we      ),
    .waddr_i   ( rf_waddr   ),
    .wdata_i   ( rf_wdata   )
  );

  //////////////////////////////////////////////////
  // Stores
  //////////////////////////////////////////////////

  rv_load_store_unit u_load_store_unit (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .store         ( store_bus     ),
    .data_req_o    ( data_req_o    ),
    .data_we_o     ( data_we_o     ),
    .data_be_o     ( data_be_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i )
  );

endmodule

//--- logic/rv_load_store_unit.sv
/*
 * Store unit on the data OBI bus
 * One store in flight, busy until its rvalid
 */
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_load_store_unit import rv_core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // From EX
  rv_pipe_if.consumer store,
  // Data OBI bus
  output logic        data_req_o,
  output logic        data_we_o,
  output logic [3:0]  data_be_o,
  output word_t       data_addr_o,
  output word_t       data_wdata_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i
);

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_RESP
  } lsu_state_e;

  lsu_state_e state_q;
  store_req_t req_q;
  logic       accept;

  // Takes a new store only when idle
  assign store.ready = (state_q == LSU_IDLE);
  assign accept      = store.valid && store.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= LSU_IDLE;
    end else begin
      case (state_q)
        LSU_IDLE: begin
          if (accept) begin
            state_q <= LSU_REQ;
          end
        end
        LSU_REQ: begin
          if (data_gnt_i) begin
            state_q <= LSU_RESP;
          end
        end
        LSU_RESP: begin
          if (data_rvalid_i) begin
            state_q <= LSU_IDLE;
          end
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  // Registered store, held on the bus until granted
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= store.payload;
    end
  end

  assign data_req_o   = (state_q == LSU_REQ);
  assign data_we_o    = 1'b1;
  assign data_be_o    = `RV_BE_WORD;
  assign data_addr_o  = req_q.addr;
  assign data_wdata_o = req_q.wdata;

  // No response without a granted store
  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    data_rvalid_i |-> state_q == LSU_RESP);

endmodule

//--- logic/rv_register_file.sv
/*
 * Integer register file, two read ports and one write port
 * x0 reads as zero
 */
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_register_file import rv_core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // Read ports
  input  rf_addr_t raddr_a_i,
  input  rf_addr_t raddr_b_i,
  output word_t    rdata_a_o,
  output word_t    rdata_b_o,
  // Write port
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  word_t    wdata_i
);

  word_t regs_q [`RV_NUM_REGS];

  // Flop array, writes to x0 dropped
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- logic/rv_ex_stage.sv
/*
 * Decode and execute stage
 * ALU results go to the register file on accept, SW goes to the LSU
 */
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_ex_stage import rv_core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // From IF
  rv_pipe_if.consumer if_id,
  // To LSU
  rv_pipe_if.producer store,
  // Register file read ports
  output rf_addr_t    rf_raddr_a_o,
  output rf_addr_t    rf_raddr_b_o,
  input  word_t       rf_rdata_a_i,
  input  word_t       rf_rdata_b_i,
  // Register file write port
  output logic        rf_we_o,
  output rf_addr_t    rf_waddr_o,
  output word_t       rf_wdata_o
);

  if_id_t     item;
  word_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;
  alu_op_e    alu_op;
  word_t      alu_b;
  word_t      alu_result;
  logic       rf_write;
  logic       is_store;
  store_req_t st_req;

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////

  assign item   = if_id.payload;
  assign instr  = item.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Sign extended I and S forms, U in upper bits
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  assign rf_raddr_a_o = instr[19:15];
  assign rf_raddr_b_o = instr[24:20];

  //////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////

  // Anything not matched retires with no effect
  always_comb begin
    alu_op   = ALU_ADD;
    alu_b    = rf_rdata_b_i;
    rf_write = 1'b0;
    is_store = 1'b0;
    case (opcode)
      `RV_OPC_OP_IMM: begin
        if (funct3 == `RV_F3_ADD) begin
          alu_b    = imm_i;
          rf_write = 1'b1;
        end
      end
      `RV_OPC_OP: begin
        if (funct3 == `RV_F3_ADD && funct7 == 7'b0) begin
          rf_write = 1'b1;
        end else if (funct3 == `RV_F3_ADD && funct7 == `RV_F7_SUB) begin
          alu_op   = ALU_SUB;
          rf_write = 1'b1;
        end else if (funct3 == `RV_F3_XOR && funct7 == 7'b0) begin
          alu_op   = ALU_XOR;
          rf_write = 1'b1;
        end
      end
      `RV_OPC_LUI: begin
        alu_op   = ALU_PASS_B;
        alu_b    = imm_u;
        rf_write = 1'b1;
      end
      `RV_OPC_STORE: begin
        is_store = (funct3 == `RV_F3_SW);
      end
      default: begin
        rf_write = 1'b0;
      end
    endcase
  end

  // ALU
  always_comb begin
    case (alu_op)
      ALU_ADD: alu_result = rf_rdata_a_i + alu_b;
      ALU_SUB: alu_result = rf_rdata_a_i - alu_b;
      ALU_XOR: alu_result = rf_rdata_a_i ^ alu_b;
      default: alu_result = alu_b;
    endcase
  end

  // Write lands on the accepting edge, next instruction reads it
  assign rf_we_o    = if_id.valid && rf_write;
  assign rf_waddr_o = instr[11:7];
  assign rf_wdata_o = alu_result;

  // Store issue, rs1 plus offset
  assign st_req.addr   = rf_rdata_a_i + imm_s;
  assign st_req.wdata  = rf_rdata_b_i;
  assign store.valid   = if_id.valid && is_store;
  assign store.payload = st_req;

  // Stall only a store the LSU cannot take
  assign if_id.ready = !is_store || store.ready;

  // Stalled store stays offered unchanged, relies on IF holding its slot
  a_store_held: assert property (@(posedge clk_i) disable iff (rst_i)
    store.valid && !store.ready |=> store.valid && $stable(store.payload));

endmodule

//--- logic/rv_if_stage.sv
/*
 * Fetch unit of the core
 * Drives the instruction OBI bus and hands instructions to EX over valid/ready
 */
`timescale 1ns/1ps

module rv_if_stage import rv_core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        fetch_enable_i,
  input  word_t       boot_addr_i,
  // Instruction OBI bus
  output logic        instr_req_o,
  output word_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  word_t       instr_rdata_i,
  // To EX
  rv_pipe_if.producer if_id
);

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;
  word_t        fetch_pc_q;
  word_t        req_pc_q;
  if_id_t       resp_item;
  if_id_t       out_q;
  if_id_t       skid_q;
  logic         out_valid_q;
  logic         skid_valid_q;
  logic         skid_valid_d;
  logic         out_free;
  logic         can_issue;
  logic         granted;

  // Output slot empties or drains this cycle
  assign out_free     = !out_valid_q || if_id.ready;
  assign skid_valid_d = out_free ? 1'b0 : (skid_valid_q || instr_rvalid_i);
  // Issue only if a landing slot is certain for the response
  assign can_issue    = fetch_enable_i && !skid_valid_d;

  // Next request may start in the rvalid cycle itself
  assign instr_req_o  = (state_q == FETCH_REQ) ||
                        ((state_q == FETCH_WAIT) && instr_rvalid_i && can_issue);
  assign instr_addr_o = fetch_pc_q;
  assign granted      = instr_req_o && instr_gnt_i;

  assign resp_item.pc    = req_pc_q;
  assign resp_item.instr = instr_rdata_i;

  // Fetch FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (can_issue) begin
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          if (granted) begin
            state_d = FETCH_WAIT;
          end else if (instr_req_o) begin
            state_d = FETCH_REQ;
          end else begin
            state_d = FETCH_IDLE;
          end
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= FETCH_IDLE;
      fetch_pc_q   <= boot_addr_i;
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      skid_valid_q <= skid_valid_d;
      if (granted) begin
        fetch_pc_q <= fetch_pc_q + 32'd4;
      end
      if (out_free) begin
        out_valid_q <= skid_valid_q || instr_rvalid_i;
      end
    end
  end

  // Payload side, skid entry drains first
  always_ff @(posedge clk_i) begin
    if (granted) begin
      req_pc_q <= fetch_pc_q;
    end
    if (out_free) begin
      if (skid_valid_q) begin
        out_q <= skid_q;
      end else if (instr_rvalid_i) begin
        out_q <= resp_item;
      end
    end else if (instr_rvalid_i) begin
      skid_q <= resp_item;
    end
  end

  assign if_id.valid   = out_valid_q;
  assign if_id.payload = out_q;

  // OBI rules on the fetch side
  a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_rvalid_i |-> state_q == FETCH_WAIT);

endmodule

//--- logic/rv_pipe_if.sv
/*
 * Valid/ready link between two pipeline stages
 * Payload type is set per instance
 */
`timescale 1ns/1ps

interface rv_pipe_if #(
  parameter type T = logic
) ();

  // Transfer on a clock edge with valid and ready both high
  logic valid;
  logic ready;
  T     payload;

  // Upstream side holds valid and payload until the transfer
  modport producer (
    output valid,
    output payload,
    input  ready
  );

  // Downstream side
  modport consumer (
    input  valid,
    input  payload,
    output ready
  );

endinterface

//--- logic/rv_core_pkg.sv
/*
 * Shared types of the RV32I core
 * Imported by the stages, the register file and the top level
 */
`include "rv_core_macros.svh"

package rv_core_pkg;

  // Machine word and register index
  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] rf_addr_t;

  // ALU function select
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  //////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////

  // IF to EX
  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  // EX to LSU, word stores only
  typedef struct packed {
    word_t addr;
    word_t wdata;
  } store_req_t;

endpackage

//--- include/rv_core_macros.svh
/*
 * Width, opcode and funct constants of the RV32I core
 * Included by the package, the RTL and the testbench
 */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Datapath size
`define RV_XLEN       32
`define RV_NUM_REGS   32

// Major opcodes in instr[6:0]
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP     7'b0110011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_STORE  7'b0100011

// funct3 codes in instr[14:12]
`define RV_F3_ADD     3'b000
`define RV_F3_XOR     3'b100
`define RV_F3_SW      3'b010

// funct7 that turns ADD into SUB
`define RV_F7_SUB     7'b0100000

// All four byte lanes
`define RV_BE_WORD    4'b1111

`endif
